//--- cp0_pkg.sv
package cp0_pkg;

    // Plain vector types
    typedef logic [31:0] word_t;        // Data, PC or register word
    typedef logic [7:0]  cp0_addr_t;    // {rd, sel}
    typedef logic [18:0] vpn2_t;        // Address bits 31..13
    typedef logic [7:0]  asid_t;
    typedef logic [3:0]  tlb_index_t;
    typedef logic [25:0] entrylo_t;     // PFN 25..6, C 5..3, D 2, V 1, G 0
    typedef logic [4:0]  exc_code_t;

    typedef enum logic [4:0] {
        EXC_NONE,
        EXC_INT,
        EXC_ITLB_REFILL,
        EXC_ITLB_INVALID,
        EXC_DTLB_RD_REFILL,
        EXC_DTLB_RD_INVALID,
        EXC_DTLB_WR_REFILL,
        EXC_DTLB_WR_INVALID,
        EXC_DTLB_MODIFIED,
        EXC_ADEL,
        EXC_ADES,
        EXC_SYS,
        EXC_BP,
        EXC_RI,
        EXC_CPU,
        EXC_OV,
        EXC_TRAP
    } exc_type_t;

    // Register addresses
    localparam cp0_addr_t ADDR_INDEX    = 8'h00;
    localparam cp0_addr_t ADDR_ENTRYLO0 = 8'h10;
    localparam cp0_addr_t ADDR_ENTRYLO1 = 8'h18;
    localparam cp0_addr_t ADDR_BADVADDR = 8'h40;
    localparam cp0_addr_t ADDR_COUNT    = 8'h48;
    localparam cp0_addr_t ADDR_ENTRYHI  = 8'h50;
    localparam cp0_addr_t ADDR_COMPARE  = 8'h58;
    localparam cp0_addr_t ADDR_STATUS   = 8'h60;
    localparam cp0_addr_t ADDR_CAUSE    = 8'h68;
    localparam cp0_addr_t ADDR_EPC      = 8'h70;

    localparam int ENTRYLO_COUNT = 2;
    localparam cp0_addr_t ENTRYLO_ADDR [ENTRYLO_COUNT] = '{ADDR_ENTRYLO0, ADDR_ENTRYLO1};

    localparam exc_code_t EXC_CODE_NONE = 5'h1f;

    // Status fields
    localparam int STATUS_BEV_BIT = 22;
    localparam int STATUS_IM_HI   = 15;
    localparam int STATUS_IM_LO   = 8;
    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_IE_BIT  = 0;

    // Cause fields
    localparam int CAUSE_BD_BIT  = 31;
    localparam int CAUSE_TI_BIT  = 30;
    localparam int CAUSE_IP_HI   = 15;
    localparam int CAUSE_IP_LO   = 8;
    localparam int CAUSE_EXC_HI  = 6;
    localparam int CAUSE_EXC_LO  = 2;

endpackage

//--- cp0_write_decode.sv
`timescale 1ns/10ps

module cp0_write_decode import cp0_pkg::*; (
    input  cp0_addr_t                rd_sel,
    input  logic                     m1s_valid,
    input  logic                     inst_mtc0,
    input  logic                     inst_eret,
    input  logic                     ex,
    input  exc_type_t                exc_type,
    output logic                     wr_status,
    output logic                     wr_cause,
    output logic                     wr_count,
    output logic                     wr_compare,
    output logic                     wr_epc,
    output logic                     wr_entryhi,
    output logic                     wr_index,
    output logic [ENTRYLO_COUNT-1:0] entrylo_we,
    output logic                     eret_flush,
    output logic                     tlb_ex_fetch,
    output logic                     tlb_ex_data
);

    logic mtc0_we;

    // An exception in the same stage kills the write
    assign mtc0_we    = m1s_valid && inst_mtc0 && !ex;
    assign eret_flush = m1s_valid && inst_eret && !ex;

    assign wr_status  = mtc0_we && (rd_sel == ADDR_STATUS);
    assign wr_cause   = mtc0_we && (rd_sel == ADDR_CAUSE);
    assign wr_count   = mtc0_we && (rd_sel == ADDR_COUNT);
    assign wr_compare = mtc0_we && (rd_sel == ADDR_COMPARE);
    assign wr_epc     = mtc0_we && (rd_sel == ADDR_EPC);
    assign wr_entryhi = mtc0_we && (rd_sel == ADDR_ENTRYHI);
    assign wr_index   = mtc0_we && (rd_sel == ADDR_INDEX);

    always_comb begin
        for (int i = 0; i < ENTRYLO_COUNT; i++) begin
            entrylo_we[i] = mtc0_we && (rd_sel == ENTRYLO_ADDR[i]);
        end
    end

    // TLB exception class picks the VPN2 source in EntryHi
    assign tlb_ex_fetch = ex && (exc_type inside {EXC_ITLB_REFILL, EXC_ITLB_INVALID});
    assign tlb_ex_data  = ex && (exc_type inside {EXC_DTLB_RD_REFILL, EXC_DTLB_RD_INVALID,
                                                  EXC_DTLB_WR_REFILL, EXC_DTLB_WR_INVALID,
                                                  EXC_DTLB_MODIFIED});

    always_comb begin
        assert final ($onehot0(entrylo_we))
            else $error("Two EntryLo enables active");
        assert final (!(eret_flush && (wr_status || wr_cause || wr_count || wr_compare ||
                                       wr_epc || wr_entryhi || wr_index || (|entrylo_we))))
            else $error("eret flush together with a register write");
    end

endmodule

//--- cp0_timer.sv
`timescale 1ns/10ps

module cp0_timer import cp0_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  wr_count,
    input  logic  wr_compare,
    input  word_t wr_data,
    output word_t count,
    output word_t compare,
    output logic  timer_int
);

    logic tick;    // Count steps at half the clock rate

    always_ff @(posedge clk) begin
        if (reset) begin
            tick    <= 1'b0;
            count   <= '0;
            compare <= '1;    // Far from Count after reset
        end else begin
            tick <= ~tick;
            if (wr_count) begin
                count <= wr_data;
            end else if (tick) begin
                count <= count + 32'd1;
            end
            if (wr_compare) begin
                compare <= wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (wr_compare) begin
            timer_int <= 1'b0;    // Acknowledge by rewriting Compare
        end else if (count == compare) begin
            timer_int <= 1'b1;
        end
    end

endmodule

//--- cp0_exception_state.sv
`timescale 1ns/10ps

module cp0_exception_state import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_status,
    input  logic       wr_cause,
    input  logic       wr_epc,
    input  word_t      wr_data,
    input  logic       ex,
    input  exc_type_t  exc_type,
    input  logic       bd,
    input  word_t      pc,
    input  logic       eret_flush,
    input  logic [5:0] ext_int,
    input  logic       timer_int,
    output word_t      status,
    output word_t      cause,
    output word_t      epc,
    output word_t      badvaddr
);

    logic       bev;
    logic [7:0] im;
    logic       exl;
    logic       ie;
    logic       cause_bd;
    logic [7:0] ip;
    exc_code_t  exc_code;

    function automatic exc_code_t map_exc_code(input exc_type_t t);
        case (t)
            EXC_INT:                               return 5'd0;
            EXC_ITLB_REFILL, EXC_ITLB_INVALID,
            EXC_DTLB_RD_REFILL, EXC_DTLB_RD_INVALID: return 5'd2;
            EXC_DTLB_WR_REFILL, EXC_DTLB_WR_INVALID: return 5'd3;
            EXC_DTLB_MODIFIED:                     return 5'd1;
            EXC_ADEL:                              return 5'd4;
            EXC_ADES:                              return 5'd5;
            EXC_SYS:                               return 5'd8;
            EXC_BP:                                return 5'd9;
            EXC_RI:                                return 5'd10;
            EXC_CPU:                               return 5'd11;
            EXC_OV:                                return 5'd12;
            EXC_TRAP:                              return 5'd13;
            default:                               return EXC_CODE_NONE;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            bev      <= 1'b1;
            im       <= '0;
            ie       <= 1'b0;
            exl      <= 1'b0;
            cause_bd <= 1'b0;
            ip       <= '0;
            exc_code <= EXC_CODE_NONE;
            epc      <= '0;
            badvaddr <= '0;
        end else begin
            if (wr_status) begin
                bev <= wr_data[STATUS_BEV_BIT];
                im  <= wr_data[STATUS_IM_HI:STATUS_IM_LO];
                ie  <= wr_data[STATUS_IE_BIT];
            end
            if (ex) begin
                exl <= 1'b1;
            end else if (eret_flush) begin
                exl <= 1'b0;
            end else if (wr_status) begin
                exl <= wr_data[STATUS_EXL_BIT];
            end
            // Nested exceptions keep the first return point
            if (ex && !exl) begin
                cause_bd <= bd;
                epc      <= bd ? pc - 32'd4 : pc;    // Point at the branch
            end else if (wr_epc) begin
                epc <= wr_data;
            end
            ip[7:2] <= {ext_int[5] | timer_int, ext_int[4:0]};
            if (wr_cause) begin
                ip[1:0] <= wr_data[CAUSE_IP_LO+1:CAUSE_IP_LO];    // Software interrupts
            end
            if (ex) begin
                exc_code <= map_exc_code(exc_type);
                case (exc_type)
                    EXC_ADES: badvaddr <= wr_data;
                    EXC_ADEL: badvaddr <= (pc[1:0] != 2'b00) ? pc : wr_data;
                    EXC_ITLB_REFILL, EXC_ITLB_INVALID: badvaddr <= pc;
                    EXC_DTLB_RD_REFILL, EXC_DTLB_RD_INVALID, EXC_DTLB_WR_REFILL,
                    EXC_DTLB_WR_INVALID, EXC_DTLB_MODIFIED: badvaddr <= wr_data;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        status = '0;
        status[STATUS_BEV_BIT]            = bev;
        status[STATUS_IM_HI:STATUS_IM_LO] = im;
        status[STATUS_EXL_BIT]            = exl;
        status[STATUS_IE_BIT]             = ie;
        cause = '0;
        cause[CAUSE_BD_BIT]                = cause_bd;
        cause[CAUSE_TI_BIT]                = timer_int;
        cause[CAUSE_IP_HI:CAUSE_IP_LO]     = ip;
        cause[CAUSE_EXC_HI:CAUSE_EXC_LO]   = exc_code;
    end

    exl_after_ex: assert property (@(posedge clk) disable iff (reset) ex |=> exl)
        else $error("EXL not set after exception");

endmodule

//--- cp0_entrylo.sv
`timescale 1ns/10ps

module cp0_entrylo import cp0_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     wr_en,
    input  entrylo_t wr_data,
    input  logic     tlbr,
    input  entrylo_t tlb_data,
    output entrylo_t entry
);

    // PFN, C, D, V and G kept in register layout
    always_ff @(posedge clk) begin
        if (reset) begin
            entry <= '0;
        end else if (wr_en) begin
            entry <= wr_data;    // mtc0 wins over tlbr
        end else if (tlbr) begin
            entry <= tlb_data;
        end
    end

endmodule

//--- cp0_tlb_regs.sv
`timescale 1ns/10ps

module cp0_tlb_regs import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_entryhi,
    input  logic       wr_index,
    input  word_t      wr_data,
    input  logic       tlbr,
    input  vpn2_t      tlb_vpn2,
    input  asid_t      tlb_asid,
    input  logic       tlbp,
    input  logic       tlb_found,
    input  tlb_index_t tlb_index,
    input  logic       tlb_ex_fetch,
    input  logic       tlb_ex_data,
    input  word_t      pc,
    output vpn2_t      entryhi_vpn2,
    output asid_t      entryhi_asid,
    output logic       index_p,
    output tlb_index_t index
);

    always_ff @(posedge clk) begin
        if (reset) begin
            entryhi_vpn2 <= '0;
            entryhi_asid <= '0;
        end else if (wr_entryhi) begin
            entryhi_vpn2 <= wr_data[31:13];
            entryhi_asid <= wr_data[7:0];
        end else if (tlbr) begin
            entryhi_vpn2 <= tlb_vpn2;
            entryhi_asid <= tlb_asid;
        end else if (tlb_ex_fetch) begin
            entryhi_vpn2 <= pc[31:13];    // Refill handler sees the faulting page
        end else if (tlb_ex_data) begin
            entryhi_vpn2 <= wr_data[31:13];
        end
    end

    // P is only changed by a probe
    always_ff @(posedge clk) begin
        if (reset) begin
            index_p <= 1'b0;
            index   <= '0;
        end else begin
            if (tlbp) begin
                index_p <= ~tlb_found;
            end
            if (wr_index) begin
                index <= wr_data[3:0];
            end else if (tlbp && tlb_found) begin
                index <= tlb_index;
            end
        end
    end

endmodule

//--- cp0_read_mux.sv
`timescale 1ns/10ps

module cp0_read_mux import cp0_pkg::*; (
    input  cp0_addr_t  rd_sel,
    input  word_t      status,
    input  word_t      cause,
    input  word_t      epc,
    input  word_t      badvaddr,
    input  word_t      count,
    input  word_t      compare,
    input  vpn2_t      entryhi_vpn2,
    input  asid_t      entryhi_asid,
    input  logic       index_p,
    input  tlb_index_t index,
    input  entrylo_t   entrylo [ENTRYLO_COUNT],
    output word_t      cp0_data
);

    always_comb begin
        case (rd_sel)
            ADDR_STATUS:   cp0_data = status;
            ADDR_CAUSE:    cp0_data = cause;
            ADDR_EPC:      cp0_data = epc;
            ADDR_BADVADDR: cp0_data = badvaddr;
            ADDR_COUNT:    cp0_data = count;
            ADDR_COMPARE:  cp0_data = compare;
            ADDR_ENTRYHI:  cp0_data = {entryhi_vpn2, 5'b0, entryhi_asid};
            ADDR_INDEX:    cp0_data = {index_p, 27'b0, index};
            default:       cp0_data = '0;    // Unmapped reads as zero
        endcase
        // EntryLo addresses do not overlap the ones above
        for (int i = 0; i < ENTRYLO_COUNT; i++) begin
            if (rd_sel == ENTRYLO_ADDR[i]) begin
                cp0_data = {6'b0, entrylo[i]};
            end
        end
    end

endmodule

//--- cp0_top.sv
`timescale 1ns/10ps

module cp0_top import cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] m1s_mtc0_rd,
    input  logic [2:0] m1s_sel,
    input  logic       m1s_valid,
    input  logic       inst_mtc0,
    input  logic       inst_eret,
    input  logic       bd,
    input  logic       ex,
    input  word_t      alu_result,    // mtc0 data, also the faulting data address
    input  logic [5:0] ext_int,
    input  exc_type_t  exc_type,
    input  word_t      pc,
    input  logic       inst_tlbr,
    input  logic       inst_tlbp,
    input  logic       tlb_found,
    input  vpn2_t      tlb_vpn2_in,
    input  asid_t      tlb_asid_in,
    input  tlb_index_t tlb_index_in,
    input  entrylo_t   tlb_entrylo_in [ENTRYLO_COUNT],
    output word_t      cp0_data,
    output logic       eret_flush,
    output vpn2_t      tlb_vpn2,
    output asid_t      tlb_asid,
    output tlb_index_t tlb_index,
    output entrylo_t   tlb_entrylo [ENTRYLO_COUNT],
    output word_t      epc,
    output logic       status_ie,
    output logic       status_exl,
    output logic [7:0] status_im,
    output logic [7:0] cause_ip,
    output logic       cause_ti
);

    cp0_addr_t                rd_sel;
    logic                     wr_status, wr_cause, wr_count, wr_compare;
    logic                     wr_epc, wr_entryhi, wr_index;
    logic [ENTRYLO_COUNT-1:0] entrylo_we;
    logic                     tlb_ex_fetch, tlb_ex_data;
    word_t                    count, compare, status, cause, badvaddr;
    logic                     index_p;

    assign rd_sel = {m1s_mtc0_rd, m1s_sel};

    cp0_write_decode u_decode (.rd_sel, .m1s_valid, .inst_mtc0, .inst_eret, .ex, .exc_type,
        .wr_status, .wr_cause, .wr_count, .wr_compare, .wr_epc, .wr_entryhi, .wr_index,
        .entrylo_we, .eret_flush, .tlb_ex_fetch, .tlb_ex_data);

    cp0_timer u_timer (.clk, .reset, .wr_count, .wr_compare, .wr_data(alu_result),
        .count, .compare, .timer_int(cause_ti));

    cp0_exception_state u_exc (.clk, .reset, .wr_status, .wr_cause, .wr_epc,
        .wr_data(alu_result), .ex, .exc_type, .bd, .pc, .eret_flush, .ext_int,
        .timer_int(cause_ti), .status, .cause, .epc, .badvaddr);

    for (genvar i = 0; i < ENTRYLO_COUNT; i++) begin : g_entrylo
        cp0_entrylo u_entrylo (.clk, .reset, .wr_en(entrylo_we[i]),
            .wr_data(alu_result[25:0]), .tlbr(inst_tlbr), .tlb_data(tlb_entrylo_in[i]),
            .entry(tlb_entrylo[i]));
    end

    cp0_tlb_regs u_tlb (.clk, .reset, .wr_entryhi, .wr_index, .wr_data(alu_result),
        .tlbr(inst_tlbr), .tlb_vpn2(tlb_vpn2_in), .tlb_asid(tlb_asid_in),
        .tlbp(inst_tlbp), .tlb_found, .tlb_index(tlb_index_in), .tlb_ex_fetch,
        .tlb_ex_data, .pc, .entryhi_vpn2(tlb_vpn2), .entryhi_asid(tlb_asid),
        .index_p, .index(tlb_index));

    cp0_read_mux u_mux (.rd_sel, .status, .cause, .epc, .badvaddr, .count, .compare,
        .entryhi_vpn2(tlb_vpn2), .entryhi_asid(tlb_asid), .index_p, .index(tlb_index),
        .entrylo(tlb_entrylo), .cp0_data);

    assign status_ie  = status[STATUS_IE_BIT];
    assign status_exl = status[STATUS_EXL_BIT];
    assign status_im  = status[STATUS_IM_HI:STATUS_IM_LO];
    assign cause_ip   = cause[CAUSE_IP_HI:CAUSE_IP_LO];

endmodule

//--- cp0_tb.sv
`timescale 1ns/10ps

module cp0_tb import cp0_pkg::*; ();

    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT    = NUM_CYCLES + 200;    // Random run plus reset margin

    logic       clk;
    logic       reset;
    logic [4:0] m1s_mtc0_rd;
    logic [2:0] m1s_sel;
    logic       m1s_valid;
    logic       inst_mtc0;
    logic       inst_eret;
    logic       bd;
    logic       ex;
    word_t      alu_result;
    logic [5:0] ext_int;
    exc_type_t  exc_type;
    word_t      pc;
    logic       inst_tlbr;
    logic       inst_tlbp;
    logic       tlb_found;
    vpn2_t      tlb_vpn2_in;
    asid_t      tlb_asid_in;
    tlb_index_t tlb_index_in;
    entrylo_t   tlb_entrylo_in [ENTRYLO_COUNT];
    word_t      cp0_data;
    logic       eret_flush;
    vpn2_t      tlb_vpn2;
    asid_t      tlb_asid;
    tlb_index_t tlb_index;
    entrylo_t   tlb_entrylo [ENTRYLO_COUNT];
    word_t      epc;
    logic       status_ie;
    logic       status_exl;
    logic [7:0] status_im;
    logic [7:0] cause_ip;
    logic       cause_ti;

    // Reference model state
    logic       m_tick, m_ti, m_bev, m_ie, m_exl, m_bd, m_p;
    word_t      m_count, m_compare, m_epc, m_badvaddr;
    logic [7:0] m_im, m_ip;
    exc_code_t  m_code;
    vpn2_t      m_vpn2;
    asid_t      m_asid;
    tlb_index_t m_index;
    entrylo_t   m_lo [ENTRYLO_COUNT];

    integer seed = 32'hd6a23c94;
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;

    // Mapped registers first, then near misses that must read zero
    cp0_addr_t addr_list [16] = '{ADDR_INDEX, ADDR_ENTRYLO0, ADDR_ENTRYLO1, ADDR_BADVADDR,
        ADDR_COUNT, ADDR_ENTRYHI, ADDR_COMPARE, ADDR_STATUS, ADDR_CAUSE, ADDR_EPC,
        8'h08, 8'h11, 8'h49, 8'h61, 8'h78, 8'hff};

    cp0_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic exc_code_t expected_code(input exc_type_t t);
        if (t == EXC_INT) return 5'd0;
        if (t inside {EXC_ITLB_REFILL, EXC_ITLB_INVALID, EXC_DTLB_RD_REFILL,
                      EXC_DTLB_RD_INVALID}) return 5'd2;
        if (t inside {EXC_DTLB_WR_REFILL, EXC_DTLB_WR_INVALID}) return 5'd3;
        if (t == EXC_DTLB_MODIFIED) return 5'd1;
        if (t == EXC_ADEL) return 5'd4;
        if (t == EXC_ADES) return 5'd5;
        if (t inside {EXC_SYS, EXC_BP, EXC_RI, EXC_CPU, EXC_OV, EXC_TRAP}) begin
            return 5'(int'(t) - int'(EXC_SYS) + 8);    // SYS..TRAP are codes 8..13
        end
        return EXC_CODE_NONE;
    endfunction

    function automatic word_t expected_read(input cp0_addr_t a);
        word_t w;
        w = '0;
        case (a)
            ADDR_STATUS: begin
                w[STATUS_BEV_BIT] = m_bev;
                w[STATUS_IM_HI:STATUS_IM_LO] = m_im;
                w[STATUS_EXL_BIT] = m_exl;
                w[STATUS_IE_BIT] = m_ie;
            end
            ADDR_CAUSE: begin
                w[CAUSE_BD_BIT] = m_bd;
                w[CAUSE_TI_BIT] = m_ti;
                w[CAUSE_IP_HI:CAUSE_IP_LO] = m_ip;
                w[CAUSE_EXC_HI:CAUSE_EXC_LO] = m_code;
            end
            ADDR_EPC:      w = m_epc;
            ADDR_BADVADDR: w = m_badvaddr;
            ADDR_COUNT:    w = m_count;
            ADDR_COMPARE:  w = m_compare;
            ADDR_ENTRYHI:  w = {m_vpn2, 5'b0, m_asid};
            ADDR_INDEX:    w = {m_p, 27'b0, m_index};
            ADDR_ENTRYLO0: w = {6'b0, m_lo[0]};
            ADDR_ENTRYLO1: w = {6'b0, m_lo[1]};
            default:       w = '0;
        endcase
        return w;
    endfunction

    task automatic reset_model();
        {m_tick, m_ti, m_ie, m_exl, m_bd, m_p} = '0;
        m_bev = 1'b1;
        {m_count, m_epc, m_badvaddr} = '0;
        m_compare = '1;
        {m_im, m_ip, m_vpn2, m_asid, m_index} = '0;
        m_code = EXC_CODE_NONE;
        m_lo[0] = '0;
        m_lo[1] = '0;
    endtask

    // One clock of the model, from the inputs the DUT sampled on this edge
    task automatic update_model();
        cp0_addr_t a;
        logic      we;
        logic      flush;
        logic      itlb;
        logic      dtlb;
        a     = {m1s_mtc0_rd, m1s_sel};
        we    = m1s_valid && inst_mtc0 && !ex;
        flush = m1s_valid && inst_eret && !ex;
        itlb  = exc_type inside {EXC_ITLB_REFILL, EXC_ITLB_INVALID};
        dtlb  = exc_type inside {EXC_DTLB_RD_REFILL, EXC_DTLB_RD_INVALID, EXC_DTLB_WR_REFILL,
                                 EXC_DTLB_WR_INVALID, EXC_DTLB_MODIFIED};
        m_ip[7:2] = {ext_int[5] | m_ti, ext_int[4:0]};    // Old TI
        if (we && a == ADDR_CAUSE) m_ip[1:0] = alu_result[CAUSE_IP_LO+1:CAUSE_IP_LO];
        if (we && a == ADDR_COMPARE) m_ti = 1'b0;
        else if (m_count == m_compare) m_ti = 1'b1;
        if (we && a == ADDR_COUNT) m_count = alu_result;
        else if (m_tick) m_count = m_count + 32'd1;
        m_tick = ~m_tick;
        if (we && a == ADDR_COMPARE) m_compare = alu_result;
        if (ex && !m_exl) begin
            m_bd  = bd;
            m_epc = bd ? pc - 32'd4 : pc;
        end else if (we && a == ADDR_EPC) begin
            m_epc = alu_result;
        end
        if (we && a == ADDR_STATUS) begin
            m_bev = alu_result[STATUS_BEV_BIT];
            m_im  = alu_result[STATUS_IM_HI:STATUS_IM_LO];
            m_ie  = alu_result[STATUS_IE_BIT];
        end
        if (ex) m_exl = 1'b1;
        else if (flush) m_exl = 1'b0;
        else if (we && a == ADDR_STATUS) m_exl = alu_result[STATUS_EXL_BIT];
        if (ex) begin
            m_code = expected_code(exc_type);
            if (exc_type == EXC_ADEL) m_badvaddr = (pc[1:0] != 2'b00) ? pc : alu_result;
            else if (itlb) m_badvaddr = pc;
            else if (dtlb || exc_type == EXC_ADES) m_badvaddr = alu_result;
        end
        if (we && a == ADDR_ENTRYHI) begin
            m_vpn2 = alu_result[31:13];
            m_asid = alu_result[7:0];
        end else if (inst_tlbr) begin
            m_vpn2 = tlb_vpn2_in;
            m_asid = tlb_asid_in;
        end else if (ex && itlb) begin
            m_vpn2 = pc[31:13];
        end else if (ex && dtlb) begin
            m_vpn2 = alu_result[31:13];
        end
        if (inst_tlbp) m_p = ~tlb_found;
        if (we && a == ADDR_INDEX) m_index = alu_result[3:0];
        else if (inst_tlbp && tlb_found) m_index = tlb_index_in;
        if (we && a == ADDR_ENTRYLO0) m_lo[0] = alu_result[25:0];
        else if (inst_tlbr) m_lo[0] = tlb_entrylo_in[0];
        if (we && a == ADDR_ENTRYLO1) m_lo[1] = alu_result[25:0];
        else if (inst_tlbr) m_lo[1] = tlb_entrylo_in[1];
    endtask

    // Ops 0-1 mtc0, 2 exception, 3 eret, 4 tlbr, 5 tlbp, 6-7 idle
    task automatic drive_random();
        word_t      r;
        word_t      s;
        word_t      t;
        cp0_addr_t  a;
        logic [2:0] op;
        logic       kill;
        r    = $random(seed);
        s    = $random(seed);
        t    = $random(seed);
        op   = r[2:0];
        kill = (r[12:10] == 3'b111);    // Exception on top of mtc0 or eret
        a    = addr_list[r[6:3]];
        m1s_mtc0_rd  <= a[7:3];
        m1s_sel      <= a[2:0];
        m1s_valid    <= (r[9:7] != 3'b000);
        alu_result   <= s;
        pc           <= $random(seed);
        bd           <= r[16];
        ext_int      <= r[22:17];
        exc_type     <= exc_type_t'(5'(r[31:24] % 8'd17));
        inst_mtc0    <= (op <= 3'd1);
        inst_eret    <= (op == 3'd3);
        inst_tlbr    <= (op == 3'd4);
        inst_tlbp    <= (op == 3'd5);
        ex           <= (op == 3'd2) || (kill && (op <= 3'd1 || op == 3'd3));
        tlb_found    <= r[13];
        tlb_vpn2_in  <= t[18:0];
        tlb_asid_in  <= t[26:19];
        tlb_index_in <= t[30:27];
        for (int i = 0; i < ENTRYLO_COUNT; i++) begin
            tlb_entrylo_in[i] <= entrylo_t'($random(seed));
        end
        if (op == 3'd6 && r[14]) begin    // Compare a few ticks ahead of Count
            m1s_mtc0_rd <= ADDR_COMPARE[7:3];
            m1s_sel     <= ADDR_COMPARE[2:0];
            m1s_valid   <= 1'b1;
            inst_mtc0   <= 1'b1;
            alu_result  <= m_count + {30'b0, s[1:0]} + 32'd1;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_entrylo(input string name, input entrylo_t got, input entrylo_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_vpn2(input string name, input vpn2_t got, input vpn2_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_word("cp0_data", cp0_data, expected_read({m1s_mtc0_rd, m1s_sel}));
        check_word("epc", epc, m_epc);
        check_word("status_im", {24'b0, status_im}, {24'b0, m_im});
        check_word("cause_ip", {24'b0, cause_ip}, {24'b0, m_ip});
        check_word("tlb_index/asid", {20'b0, tlb_index, tlb_asid}, {20'b0, m_index, m_asid});
        check_bit("eret_flush", eret_flush, m1s_valid && inst_eret && !ex);
        check_bit("status_exl", status_exl, m_exl);
        check_bit("status_ie", status_ie, m_ie);
        check_bit("cause_ti", cause_ti, m_ti);
        check_vpn2("tlb_vpn2", tlb_vpn2, m_vpn2);
        for (int i = 0; i < ENTRYLO_COUNT; i++) begin
            check_entrylo($sformatf("tlb_entrylo[%0d]", i), tlb_entrylo[i], m_lo[i]);
        end
    endtask

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        {m1s_mtc0_rd, m1s_sel, m1s_valid, inst_mtc0, inst_eret, bd, ex} = '0;
        {alu_result, ext_int, pc, inst_tlbr, inst_tlbp, tlb_found} = '0;
        {tlb_vpn2_in, tlb_asid_in, tlb_index_in} = '0;
        exc_type = EXC_NONE;
        tlb_entrylo_in[0] = '0;
        tlb_entrylo_in[1] = '0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        reset_model();
        @(negedge clk);
        compare_outputs();
        for (int n = 0; n < NUM_CYCLES; n++) begin
            @(posedge clk);
            update_model();
            drive_random();
            @(negedge clk);
            compare_outputs();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tb.f
cp0_pkg.sv
cp0_write_decode.sv
cp0_timer.sv
cp0_exception_state.sv
cp0_entrylo.sv
cp0_tlb_regs.sv
cp0_read_mux.sv
cp0_top.sv
cp0_tb.sv

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module cp0_tb -o cp0_sim
./obj_dir/cp0_sim | tee sim.log
if grep -q "Test failures found" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
echo "Simulation clean"
